// ==== Makefile ====
TOP = core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// address of the first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural register count, x0 included
`define CORE_REG_COUNT 32

// 1: arbiter keeps the grant on its owner until mem_ready
`define CORE_ARB_LOCK 1

`endif

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_none,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

    typedef enum logic {
        owner_ifu,
        owner_lsu
    } arb_owner_e;

endpackage

`default_nettype wire

// ==== core_properties.sv ====
`default_nettype none

module core_properties (
    input wire logic            clk,
    input wire logic            rst_n,
    input wire logic            mem_req,
    input wire core_pkg::word_t mem_addr,
    input wire logic            mem_ready,
    input wire logic            commit_valid,
    input wire logic            halted
);

    property req_held;
        @(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ready) |=> (mem_req && $stable(mem_addr));
    endproperty

    property req_drops;
        @(posedge clk) disable iff (!rst_n)
        (mem_req && mem_ready) |=> !mem_req;
    endproperty

    property commit_single;
        @(posedge clk) disable iff (!rst_n)
        commit_valid |=> !commit_valid;
    endproperty

    property quiet_after_halt;
        @(posedge clk) disable iff (!rst_n)
        halted |-> !mem_req;
    endproperty

    req_held_a: assert property (req_held)
        else $error("mem_req dropped or mem_addr moved before mem_ready");
    req_drops_a: assert property (req_drops)
        else $error("mem_req still high the cycle after mem_ready");
    commit_single_a: assert property (commit_single)
        else $error("commit_valid high for two cycles in a row");
    quiet_after_halt_a: assert property (quiet_after_halt)
        else $error("memory request raised after halt");

endmodule

bind core_top core_properties props_i (
    .clk(clk),
    .rst_n(rst_n),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .mem_ready(mem_ready),
    .commit_valid(commit_valid),
    .halted(halted)
);

`default_nettype wire

// ==== core_tb.sv ====
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int    NUM_ROWS       = 14;
    localparam int    MEM_WORDS      = 256;
    localparam int    COMMIT_TIMEOUT = 200;
    localparam int    HALT_TIMEOUT   = 20;
    localparam word_t STORE_ADDR     = 32'h0000_0200;  // x4 + 0x1fc
    localparam word_t STORE_DATA     = 32'h1234_5000;  // x2 after lui

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        reg_addr_t rd;
        logic      we;
        word_t     data;
    } row_t;

    // pc, instruction, rd, write enable, committed value
    localparam row_t ROWS [NUM_ROWS] = '{
        '{32'h00, 32'h0050_0093, 5'd1, 1'b1, 32'h0000_0005},  // addi x1, x0, 5
        '{32'h04, 32'h1234_5137, 5'd2, 1'b1, 32'h1234_5000},  // lui x2, 0x12345
        '{32'h08, 32'h0000_1197, 5'd3, 1'b1, 32'h0000_1008},  // auipc x3, 1
        '{32'h0c, 32'hfff0_8213, 5'd4, 1'b1, 32'h0000_0004},  // addi x4, x1, -1
        '{32'h10, 32'h0080_02ef, 5'd5, 1'b1, 32'h0000_0014},  // jal x5, +8
        '{32'h18, 32'h0290_0313, 5'd6, 1'b1, 32'h0000_0029},  // addi x6, x0, 0x29
        '{32'h1c, 32'h0003_03e7, 5'd7, 1'b1, 32'h0000_0020},  // jalr x7, 0(x6) to 0x28
        '{32'h28, 32'h0010_8463, 5'd0, 1'b0, 32'h0000_0000},  // beq x1, x1, +8 taken
        '{32'h30, 32'h0040_8463, 5'd0, 1'b0, 32'h0000_0000},  // beq x1, x4, +8 not taken
        '{32'h34, 32'h1e22_2e23, 5'd0, 1'b0, 32'h0000_0000},  // sw x2, 0x1fc(x4)
        '{32'h38, 32'h2000_2403, 5'd8, 1'b1, 32'h1234_5000},  // lw x8, 0x200(x0)
        '{32'h3c, 32'h0070_8013, 5'd0, 1'b0, 32'h0000_0000},  // addi x0, x1, 7
        '{32'h40, 32'h0030_0493, 5'd9, 1'b1, 32'h0000_0003},  // addi x9, x0, 3
        '{32'h44, 32'h0010_0073, 5'd0, 1'b0, 32'h0000_0000}   // ebreak
    };

    logic      clk;
    logic      rst_n = 1'b0;
    logic      mem_req;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_ready = 1'b0;
    word_t     mem_rdata = '0;
    logic      commit_valid;
    word_t     commit_pc;
    reg_addr_t commit_rd;
    logic      commit_we;
    word_t     commit_data;
    logic      halted;

    word_t       mem [MEM_WORDS];
    logic        busy;
    int unsigned wait_left;
    int          write_count;
    word_t       last_waddr;
    word_t       last_wdata;
    int          range_errors;
    int          commit_count;
    int          tests_run;
    int          tests_failed;

    core_top dut_i (
        .clk(clk), .rst_n(rst_n),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_rd(commit_rd),
        .commit_we(commit_we), .commit_data(commit_data), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t fill_word(int unsigned idx);
        return 32'hc0de_0000 ^ (idx * 32'h0001_0021);
    endfunction

    // memory responder, random latency of 0 to 3 cycles
    initial begin
        int unsigned seed_ret;
        int unsigned delay;
        seed_ret = $urandom(92146);
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                mem_ready    <= 1'b0;
                busy         <= 1'b0;
                wait_left    <= 0;
                write_count  <= 0;
                range_errors <= 0;
                for (int i = 0; i < MEM_WORDS; i++) begin
                    mem[i] <= fill_word(i);
                end
                for (int r = 0; r < NUM_ROWS; r++) begin
                    mem[ROWS[r].pc[9:2]] <= ROWS[r].inst;  // program over the fill
                end
            end else if (mem_ready) begin
                mem_ready <= 1'b0;  // one-cycle pulse
            end else if (mem_req) begin
                delay = busy ? wait_left : $urandom_range(3, 0);
                if (delay != 0) begin
                    busy      <= 1'b1;
                    wait_left <= delay - 1;
                end else begin
                    busy      <= 1'b0;
                    mem_ready <= 1'b1;
                    if ((mem_addr[31:10] != '0) || (mem_addr[1:0] != 2'b00)) begin
                        $display("memory access at %h is misaligned or outside the model",
                                 mem_addr);
                        range_errors <= range_errors + 1;
                    end
                    if (mem_we) begin
                        mem[mem_addr[9:2]] <= mem_wdata;
                        write_count        <= write_count + 1;
                        last_waddr         <= mem_addr;
                        last_wdata         <= mem_wdata;
                    end else begin
                        mem_rdata <= mem[mem_addr[9:2]];
                    end
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            commit_count <= 0;
        end else if (commit_valid) begin
            commit_count <= commit_count + 1;
        end
    end

    task automatic wait_commit(output bit got);
        int cycles;
        cycles = 0;
        got    = 1'b0;
        while (!got && (cycles < COMMIT_TIMEOUT)) begin
            @(negedge clk);
            got = commit_valid;
            cycles++;
        end
    endtask

    task automatic wait_halted(output bit got);
        int cycles;
        cycles = 0;
        got    = 1'b0;
        while (!got && (cycles < HALT_TIMEOUT)) begin
            @(negedge clk);
            got = halted;
            cycles++;
        end
    endtask

    task automatic check_commit(input int idx, input row_t row);
        int bad;
        bad = 0;
        tests_run++;
        if (commit_pc !== row.pc) begin
            $display("ERROR row %0d commit_pc: got %h expected %h", idx, commit_pc, row.pc);
            bad++;
        end
        if (commit_we !== row.we) begin
            $display("ERROR row %0d commit_we: got %h expected %h", idx, commit_we, row.we);
            bad++;
        end
        if (row.we) begin  // rd and value only matter when a register is written
            if (commit_rd !== row.rd) begin
                $display("ERROR row %0d commit_rd: got %h expected %h", idx, commit_rd, row.rd);
                bad++;
            end
            if (commit_data !== row.data) begin
                $display("ERROR row %0d commit_data: got %h expected %h",
                         idx, commit_data, row.data);
                bad++;
            end
        end
        if (bad == 0) begin
            $display("row %0d pc %h: ok", idx, row.pc);
        end else begin
            $display("row %0d pc %h: %0d mismatches", idx, row.pc, bad);
            tests_failed++;
        end
    endtask

    task automatic check_store();
        int bad;
        bad = 0;
        tests_run++;
        if (write_count != 1) begin
            $display("expected exactly one memory write but saw %0d", write_count);
            bad++;
        end
        if (last_waddr !== STORE_ADDR) begin
            $display("ERROR store mem_addr: got %h expected %h", last_waddr, STORE_ADDR);
            bad++;
        end
        if (last_wdata !== STORE_DATA) begin
            $display("ERROR store mem_wdata: got %h expected %h", last_wdata, STORE_DATA);
            bad++;
        end
        if (mem[STORE_ADDR[9:2]] !== STORE_DATA) begin
            $display("ERROR store mem[200]: got %h expected %h", mem[STORE_ADDR[9:2]], STORE_DATA);
            bad++;
        end
        if (range_errors != 0) begin
            $display("the core made %0d bad memory accesses", range_errors);
            bad++;
        end
        if (bad == 0) begin
            $display("store: ok");
        end else begin
            $display("store: %0d mismatches", bad);
            tests_failed++;
        end
    endtask

    initial begin
        bit          got;
        bit          aborted;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!aborted) begin
                wait_commit(got);
                if (!got) begin
                    $display("row %0d: no commit within %0d cycles", r, COMMIT_TIMEOUT);
                    tests_run++;
                    tests_failed++;
                    aborted = 1'b1;
                end else begin
                    check_commit(r, ROWS[r]);
                end
            end
        end
        if (!aborted) begin
            check_store();
            wait_halted(got);
            tests_run++;
            if (got) begin
                $display("halt: ok");
            end else begin
                $display("halted did not rise within %0d cycles after ebreak", HALT_TIMEOUT);
                tests_failed++;
            end
            repeat (5) @(negedge clk);  // any stray commit would show up here
            tests_run++;
            if (commit_count == NUM_ROWS) begin
                $display("commit count: ok");
            end else begin
                $display("saw %0d commits but the program has %0d", commit_count, NUM_ROWS);
                tests_failed++;
            end
        end
        $display("tests: %0d run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== core_top.sv ====
`default_nettype none

module core_top (
    input  wire logic            clk,
    input  wire logic            rst_n,
    output logic                 mem_req,
    output logic                 mem_we,
    output core_pkg::word_t      mem_addr,
    output core_pkg::word_t      mem_wdata,
    input  wire logic            mem_ready,
    input  wire core_pkg::word_t mem_rdata,
    output logic                 commit_valid,
    output core_pkg::word_t      commit_pc,
    output core_pkg::reg_addr_t  commit_rd,
    output logic                 commit_we,
    output core_pkg::word_t      commit_data,
    output logic                 halted
);
    import core_pkg::*;

    logic      fetch_req;
    word_t     fetch_addr;
    logic      fetch_ready;
    word_t     fetch_rdata;
    logic      ls_req;
    logic      ls_we;
    word_t     ls_addr;
    word_t     ls_wdata;
    logic      ls_ready;
    word_t     ls_rdata;
    word_t     pc;
    word_t     inst;
    word_t     next_pc;
    logic      is_mem;
    logic      is_halt;
    logic      is_store;
    logic      ls_start;
    logic      ls_done;
    logic      retire;
    opcode_e   opcode;
    logic [2:0] funct3;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    word_t     imm;
    logic      reg_write_en;
    logic      rf_we;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     result;
    word_t     ex_mem_addr;
    word_t     load_data;

    assign is_store = (opcode == op_store);
    assign rf_we    = retire && reg_write_en;  // write lands at the retire edge

    ifu ifu_i (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready), .fetch_rdata(fetch_rdata),
        .pc(pc), .inst(inst), .next_pc(next_pc),
        .is_mem(is_mem), .is_halt(is_halt),
        .ls_start(ls_start), .ls_done(ls_done),
        .retire(retire), .halted(halted)
    );

    idu idu_i (
        .inst(inst), .opcode(opcode), .funct3(funct3),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .imm(imm), .reg_write_en(reg_write_en),
        .is_mem(is_mem), .is_halt(is_halt)
    );

    exu exu_i (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .mem_data(load_data), .opcode(opcode), .funct3(funct3),
        .result(result), .next_pc(next_pc), .mem_addr(ex_mem_addr)
    );

    lsu lsu_i (
        .clk(clk), .rst_n(rst_n),
        .ls_start(ls_start), .is_store(is_store),
        .addr(ex_mem_addr), .wdata(rs2_data),
        .ls_req(ls_req), .ls_we(ls_we), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
        .ls_ready(ls_ready), .ls_rdata(ls_rdata),
        .load_data(load_data), .ls_done(ls_done)
    );

    mem_arbiter arb_i (
        .clk(clk), .rst_n(rst_n),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_ready(fetch_ready), .fetch_rdata(fetch_rdata),
        .ls_req(ls_req), .ls_we(ls_we), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
        .ls_ready(ls_ready), .ls_rdata(ls_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    regfile rf_i (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(rf_we), .rd_addr(rd_addr), .rd_data(result)
    );

    assign commit_valid = retire;
    assign commit_pc    = pc;
    assign commit_rd    = rd_addr;
    assign commit_we    = rf_we;
    assign commit_data  = result;

endmodule

`default_nettype wire

// ==== exu.sv ====
`default_nettype none

module exu (
    input  wire core_pkg::word_t   rs1_data,
    input  wire core_pkg::word_t   rs2_data,
    input  wire core_pkg::word_t   imm,
    input  wire core_pkg::word_t   pc,
    input  wire core_pkg::word_t   mem_data,
    input  wire core_pkg::opcode_e opcode,
    input  wire logic [2:0]        funct3,
    output core_pkg::word_t        result,
    output core_pkg::word_t        next_pc,
    output core_pkg::word_t        mem_addr
);
    import core_pkg::*;

    opcode_e a_keys [2];
    word_t   a_vals [2];
    opcode_e res_keys [3];
    word_t   res_vals [3];
    word_t   alu_a;
    word_t   alu_out;
    word_t   pc_plus4;
    word_t   pc_target;
    logic    is_jal;
    logic    is_jalr;
    logic    branch_taken;

    assign a_keys = '{op_auipc, op_lui};
    assign a_vals = '{pc, 32'h0};

    mux_key_default #(
        .NR_KEY(2),
        .key_t (opcode_e),
        .data_t(word_t)
    ) alu_a_mux (
        .key        (opcode),
        .default_out(rs1_data),
        .keys       (a_keys),
        .values     (a_vals),
        .out        (alu_a)
    );

    assign alu_out   = alu_a + imm;
    assign pc_plus4  = pc + 32'd4;  // link value
    assign pc_target = pc + imm;  // jal and beq target

    assign res_keys = '{op_jal, op_jalr, op_load};
    assign res_vals = '{pc_plus4, pc_plus4, mem_data};

    mux_key_default #(
        .NR_KEY(3),
        .key_t (opcode_e),
        .data_t(word_t)
    ) result_mux (
        .key        (opcode),
        .default_out(alu_out),
        .keys       (res_keys),
        .values     (res_vals),
        .out        (result)
    );

    assign is_jal       = (opcode == op_jal);
    assign is_jalr      = (opcode == op_jalr) && (funct3 == 3'b000);
    assign branch_taken = (opcode == op_branch) && (funct3 == 3'b000) && (rs1_data == rs2_data);

    // jalr base is rs1 since alu_a defaults to rs1
    assign next_pc = is_jal       ? pc_target :
                     is_jalr      ? {alu_out[31:1], 1'b0} :
                     branch_taken ? pc_target :
                     pc_plus4;

    assign mem_addr = alu_out;  // rs1 + imm for lw and sw

endmodule

`default_nettype wire

// ==== idu.sv ====
`default_nettype none

module idu (
    input  wire core_pkg::word_t inst,
    output core_pkg::opcode_e    opcode,
    output logic [2:0]           funct3,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    output core_pkg::reg_addr_t  rd_addr,
    output core_pkg::word_t      imm,
    output logic                 reg_write_en,
    output logic                 is_mem,
    output logic                 is_halt
);
    import core_pkg::*;

    opcode_e  fmt_keys [8];
    imm_fmt_e fmt_vals [8];
    imm_fmt_e imm_fmt;
    logic     writes_rd;

    assign opcode   = opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign rd_addr  = inst[11:7];

    assign fmt_keys = '{op_lui, op_auipc, op_jal, op_jalr, op_imm, op_load, op_store, op_branch};
    assign fmt_vals = '{fmt_u, fmt_u, fmt_j, fmt_i, fmt_i, fmt_i, fmt_s, fmt_b};

    mux_key_default #(
        .NR_KEY(8),
        .key_t (opcode_e),
        .data_t(imm_fmt_e)
    ) imm_fmt_mux (
        .key        (opcode),
        .default_out(fmt_none),
        .keys       (fmt_keys),
        .values     (fmt_vals),
        .out        (imm_fmt)
    );

    always_comb begin
        case (imm_fmt)
            fmt_i:   imm = {{20{inst[31]}}, inst[31:20]};
            fmt_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            fmt_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};
            fmt_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_lui, op_auipc, op_jal: writes_rd = 1'b1;
            op_jalr, op_imm:          writes_rd = (funct3 == 3'b000);  // jalr, addi
            op_load:                  writes_rd = (funct3 == 3'b010);  // lw only
            default:                  writes_rd = 1'b0;  // unknown retires as nop
        endcase
    end

    assign reg_write_en = writes_rd && (rd_addr != '0);
    assign is_mem  = ((opcode == op_load) || (opcode == op_store)) && (funct3 == 3'b010);
    assign is_halt = (inst == 32'h0010_0073);  // ebreak

endmodule

`default_nettype wire

// ==== ifu.sv ====
`default_nettype none
`include "core_config.svh"

module ifu (
    input  wire logic            clk,
    input  wire logic            rst_n,
    output logic                 fetch_req,
    output core_pkg::word_t      fetch_addr,
    input  wire logic            fetch_ready,
    input  wire core_pkg::word_t fetch_rdata,
    output core_pkg::word_t      pc,
    output core_pkg::word_t      inst,
    input  wire core_pkg::word_t next_pc,
    input  wire logic            is_mem,
    input  wire logic            is_halt,
    output logic                 ls_start,
    input  wire logic            ls_done,
    output logic                 retire,
    output logic                 halted
);
    import core_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_mem,
        st_retire,
        st_halt
    } state_e;

    state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            pc     <= `CORE_RESET_PC;
            halted <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    state <= st_fetch;  // one quiet cycle out of reset
                end
                st_fetch: begin
                    if (fetch_ready) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    state <= is_mem ? st_mem : st_retire;
                end
                st_mem: begin
                    if (ls_done) begin
                        state <= st_retire;
                    end
                end
                st_retire: begin
                    pc <= next_pc;
                    if (is_halt) begin
                        state  <= st_halt;
                        halted <= 1'b1;
                    end else begin
                        state <= st_fetch;
                    end
                end
                default: begin
                    state <= st_halt;  // ebreak seen, park here
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_fetch) && fetch_ready) begin
            inst <= fetch_rdata;
        end
    end

    assign fetch_req  = (state == st_fetch);
    assign fetch_addr = pc;
    assign ls_start   = (state == st_exec) && is_mem;  // single cycle, state moves on
    assign retire     = (state == st_retire);

endmodule

`default_nettype wire

// ==== lsu.sv ====
`default_nettype none

module lsu (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            ls_start,
    input  wire logic            is_store,
    input  wire core_pkg::word_t addr,
    input  wire core_pkg::word_t wdata,
    output logic                 ls_req,
    output logic                 ls_we,
    output core_pkg::word_t      ls_addr,
    output core_pkg::word_t      ls_wdata,
    input  wire logic            ls_ready,
    input  wire core_pkg::word_t ls_rdata,
    output core_pkg::word_t      load_data,
    output logic                 ls_done
);
    import core_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ls_req  <= 1'b0;
            ls_we   <= 1'b0;
            ls_done <= 1'b0;
        end else begin
            ls_done <= 1'b0;
            if (ls_start) begin
                ls_req <= 1'b1;
                ls_we  <= is_store;
            end else if (ls_req && ls_ready) begin
                ls_req  <= 1'b0;  // drop in the cycle after ready
                ls_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ls_start) begin
            ls_addr  <= addr;
            ls_wdata <= wdata;
        end
        if (ls_req && ls_ready && !ls_we) begin
            load_data <= ls_rdata;  // held for the retire cycle
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`default_nettype none
`include "core_config.svh"

module mem_arbiter (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            fetch_req,
    input  wire core_pkg::word_t fetch_addr,
    output logic                 fetch_ready,
    output core_pkg::word_t      fetch_rdata,
    input  wire logic            ls_req,
    input  wire logic            ls_we,
    input  wire core_pkg::word_t ls_addr,
    input  wire core_pkg::word_t ls_wdata,
    output logic                 ls_ready,
    output core_pkg::word_t      ls_rdata,
    output logic                 mem_req,
    output logic                 mem_we,
    output core_pkg::word_t      mem_addr,
    output core_pkg::word_t      mem_wdata,
    input  wire logic            mem_ready,
    input  wire core_pkg::word_t mem_rdata
);
    import core_pkg::*;

    arb_owner_e grant;
    arb_owner_e owner;
    logic       locked;

    always_comb begin
        if ((`CORE_ARB_LOCK != 0) && locked) begin
            grant = owner;  // transfer in flight
        end else if (ls_req) begin
            grant = owner_lsu;
        end else begin
            grant = owner_ifu;
        end
    end

    assign mem_req     = (grant == owner_lsu) ? ls_req : fetch_req;
    assign mem_we      = (grant == owner_lsu) && ls_we;
    assign mem_addr    = (grant == owner_lsu) ? ls_addr : fetch_addr;
    assign mem_wdata   = ls_wdata;
    assign fetch_ready = mem_ready && (grant == owner_ifu);
    assign ls_ready    = mem_ready && (grant == owner_lsu);
    assign fetch_rdata = mem_rdata;
    assign ls_rdata    = mem_rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner  <= owner_ifu;
            locked <= 1'b0;
        end else if (mem_req && mem_ready) begin
            locked <= 1'b0;
        end else if (mem_req) begin
            owner  <= grant;
            locked <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== mux_key_default.sv ====
`default_nettype none

module mux_key_default #(
    parameter int  NR_KEY = 2,
    parameter type key_t  = logic [6:0],
    parameter type data_t = logic [31:0]
) (
    input  wire key_t  key,
    input  wire data_t default_out,
    input  wire key_t  keys [NR_KEY],
    input  wire data_t values [NR_KEY],
    output data_t      out
);

    always_comb begin
        out = default_out;
        for (int i = 0; i < NR_KEY; i++) begin
            if (key == keys[i]) begin
                out = values[i];  // later entries win on duplicates
            end
        end
    end

endmodule

`default_nettype wire

// ==== regfile.sv ====
`default_nettype none
`include "core_config.svh"

module regfile (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire core_pkg::reg_addr_t rs1_addr,
    input  wire core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t          rs1_data,
    output core_pkg::word_t          rs2_data,
    input  wire logic                we,
    input  wire core_pkg::reg_addr_t rd_addr,
    input  wire core_pkg::word_t     rd_data
);
    import core_pkg::*;

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;  // x0 stays zero
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
core_pkg.sv
mux_key_default.sv
ifu.sv
idu.sv
exu.sv
lsu.sv
mem_arbiter.sv
regfile.sv
core_top.sv
core_properties.sv
core_tb.sv
